// ==== rv_decode_pkg.sv ====
package rv_decode_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int XLEN = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode and operation encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Major opcode, inst[6:2] of a 32-bit RV32I word.
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_OPIMM  = 5'b00100,
        OP_AUIPC  = 5'b00101,
        OP_STORE  = 5'b01000,
        OP_OPREG  = 5'b01100,
        OP_LUI    = 5'b01101,
        OP_BRANCH = 5'b11000,
        OP_JALR   = 5'b11001,
        OP_JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        INT_ADD   = 4'd0,
        INT_SUB   = 4'd1,
        INT_SLT   = 4'd2,
        INT_SLTU  = 4'd3,
        INT_XOR   = 4'd4,
        INT_OR    = 4'd5,
        INT_AND   = 4'd6,
        INT_SLL   = 4'd7,
        INT_SRL   = 4'd8,
        INT_SRA   = 4'd9,
        INT_LUI   = 4'd10,
        INT_AUIPC = 4'd11
    } int_op_e;

    typedef enum logic [2:0] {
        BR_EQ   = 3'd0,
        BR_NE   = 3'd1,
        BR_LT   = 3'd2,
        BR_GE   = 3'd3,
        BR_LTU  = 3'd4,
        BR_GEU  = 3'd5,
        BR_JAL  = 3'd6,
        BR_JALR = 3'd7
    } branch_op_e;

    typedef enum logic [3:0] {
        MEM_LB  = 4'd0,
        MEM_LH  = 4'd1,
        MEM_LW  = 4'd2,
        MEM_LBU = 4'd3,
        MEM_LHU = 4'd4,
        MEM_SB  = 4'd5,
        MEM_SH  = 4'd6,
        MEM_SW  = 4'd7
    } mem_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded instruction record
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic            intv;      // Integer unit.
        logic            branchv;   // Branch and jump unit.
        logic            memv;      // Load and store unit.
        logic            illegal;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic            we;        // Set only when rd is not x0.
        logic            immv;
        logic            sext;
        int_op_e         int_op;
        branch_op_e      branch_op;
        mem_op_e         mem_op;
        logic [XLEN-1:0] imm;
    } decode_info_t;

endpackage

// ==== imm_gen.sv ====
module imm_gen (
    input  logic [31:0]                     inst,
    input  rv_decode_pkg::opcode_e          op,
    input  logic                            is_shift,
    input  logic                            zext,
    output logic [rv_decode_pkg::XLEN-1:0]  imm
);

    logic [rv_decode_pkg::XLEN-1:0] u_imm;
    logic [rv_decode_pkg::XLEN-1:0] j_imm;
    logic [rv_decode_pkg::XLEN-1:0] b_imm;
    logic [rv_decode_pkg::XLEN-1:0] s_imm;
    logic [rv_decode_pkg::XLEN-1:0] i_imm;
    logic [rv_decode_pkg::XLEN-1:0] sh_imm;

    // Upper field sits in the low 20 bits, as the execution units expect.
    assign u_imm = {{(rv_decode_pkg::XLEN-20){inst[31]}}, inst[31:12]};

    assign j_imm = {{(rv_decode_pkg::XLEN-21){inst[31]}},
                    inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign b_imm = {{(rv_decode_pkg::XLEN-13){inst[31]}},
                    inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    assign s_imm = {{(rv_decode_pkg::XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

    assign i_imm = zext ? {{(rv_decode_pkg::XLEN-12){1'b0}}, inst[31:20]}
                        : {{(rv_decode_pkg::XLEN-12){inst[31]}}, inst[31:20]};

    assign sh_imm = {{(rv_decode_pkg::XLEN-5){1'b0}}, inst[24:20]};  // Shift amount only.

    always_comb begin
        if (is_shift) begin
            imm = sh_imm;
        end else begin
            case (op)
                rv_decode_pkg::OP_LUI,
                rv_decode_pkg::OP_AUIPC:  imm = u_imm;
                rv_decode_pkg::OP_JAL:    imm = j_imm;
                rv_decode_pkg::OP_BRANCH: imm = b_imm;
                rv_decode_pkg::OP_STORE:  imm = s_imm;
                rv_decode_pkg::OP_LOAD,
                rv_decode_pkg::OP_OPIMM,
                rv_decode_pkg::OP_JALR:   imm = i_imm;
                default:                  imm = '0;  // OPREG and unknown opcodes.
            endcase
        end
    end

endmodule

// ==== inst_decoder.sv ====
module inst_decoder (
    input  logic [31:0]                  inst,
    output rv_decode_pkg::decode_info_t  info
);

    rv_decode_pkg::opcode_e         op;
    logic [2:0]                     funct3;
    logic                           funct7_b5;
    logic                           is_opreg;
    logic                           is_shift;
    logic                           zext;
    logic                           int_cls;
    logic                           br_cls;
    logic                           mem_cls;
    logic                           op_known;
    logic                           f3_bad;
    logic                           illegal;
    logic                           use_rs1;
    logic                           use_rs2;
    logic                           use_rd;
    logic                           sext;
    logic [4:0]                     rd;
    rv_decode_pkg::int_op_e         alu_op;
    rv_decode_pkg::int_op_e         int_op;
    rv_decode_pkg::branch_op_e      branch_op;
    rv_decode_pkg::mem_op_e         mem_op;
    logic [rv_decode_pkg::XLEN-1:0] imm;

    assign op        = rv_decode_pkg::opcode_e'(inst[6:2]);
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];
    assign is_opreg  = (op == rv_decode_pkg::OP_OPREG);

    assign is_shift = (op == rv_decode_pkg::OP_OPIMM) && (funct3[1:0] == 2'b01);
    assign zext = ((op == rv_decode_pkg::OP_LOAD) && (funct3 == 3'd4 || funct3 == 3'd5)) ||
                  ((op == rv_decode_pkg::OP_OPIMM) && (funct3 == 3'd3)) ||
                  (op == rv_decode_pkg::OP_JALR);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Integer operation from funct3
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (funct3)
            3'd0:    alu_op = (is_opreg && funct7_b5) ? rv_decode_pkg::INT_SUB
                                                      : rv_decode_pkg::INT_ADD;
            3'd1:    alu_op = rv_decode_pkg::INT_SLL;
            3'd2:    alu_op = rv_decode_pkg::INT_SLT;
            3'd3:    alu_op = rv_decode_pkg::INT_SLTU;
            3'd4:    alu_op = rv_decode_pkg::INT_XOR;
            3'd5:    alu_op = funct7_b5 ? rv_decode_pkg::INT_SRA : rv_decode_pkg::INT_SRL;
            3'd6:    alu_op = rv_decode_pkg::INT_OR;
            default: alu_op = rv_decode_pkg::INT_AND;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Class, register use and unit operation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        int_cls   = 1'b0;
        br_cls    = 1'b0;
        mem_cls   = 1'b0;
        op_known  = 1'b1;
        f3_bad    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        use_rd    = 1'b0;
        sext      = 1'b0;
        int_op    = rv_decode_pkg::INT_ADD;  // Zero encodings outside the class.
        branch_op = rv_decode_pkg::BR_EQ;
        mem_op    = rv_decode_pkg::MEM_LB;
        case (op)
            rv_decode_pkg::OP_LUI: begin
                int_cls = 1'b1;
                use_rd  = 1'b1;
                int_op  = rv_decode_pkg::INT_LUI;
            end
            rv_decode_pkg::OP_AUIPC: begin
                int_cls = 1'b1;
                use_rd  = 1'b1;
                int_op  = rv_decode_pkg::INT_AUIPC;
            end
            rv_decode_pkg::OP_OPIMM,
            rv_decode_pkg::OP_OPREG: begin
                int_cls = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = is_opreg;
                use_rd  = 1'b1;
                int_op  = alu_op;
                sext    = (funct3 == 3'd2);  // SLTI and SLT.
            end
            rv_decode_pkg::OP_JAL: begin
                br_cls    = 1'b1;
                use_rd    = 1'b1;
                branch_op = rv_decode_pkg::BR_JAL;
            end
            rv_decode_pkg::OP_JALR: begin
                br_cls    = 1'b1;
                use_rs1   = 1'b1;
                use_rd    = 1'b1;
                branch_op = rv_decode_pkg::BR_JALR;
            end
            rv_decode_pkg::OP_BRANCH: begin
                br_cls    = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                f3_bad    = (funct3[2:1] == 2'b01);
                sext      = (funct3 == 3'd4) || (funct3 == 3'd5);
                branch_op = rv_decode_pkg::branch_op_e'(funct3[2] ? funct3 - 3'd2 : funct3);
            end
            rv_decode_pkg::OP_LOAD: begin
                mem_cls = 1'b1;
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                f3_bad  = (funct3 == 3'd3) || (funct3[2:1] == 2'b11);
                sext    = (funct3 == 3'd0) || (funct3 == 3'd1);  // LB and LH.
                mem_op  = rv_decode_pkg::mem_op_e'({1'b0, funct3[2] ? funct3 - 3'd1 : funct3});
            end
            rv_decode_pkg::OP_STORE: begin
                mem_cls = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                f3_bad  = (funct3 > 3'd2);
                mem_op  = rv_decode_pkg::mem_op_e'({1'b0, funct3} + 4'd5);
            end
            default: op_known = 1'b0;
        endcase
    end

    assign illegal = (inst[1:0] != 2'b11) || !op_known || f3_bad;
    assign rd      = use_rd ? inst[11:7] : 5'd0;

    imm_gen i_imm_gen (
        .inst     (inst),
        .op       (op),
        .is_shift (is_shift),
        .zext     (zext),
        .imm      (imm)
    );

    // An illegal word carries nothing but its flag.
    always_comb begin
        info         = '0;
        info.illegal = illegal;
        if (!illegal) begin
            info.intv      = int_cls;
            info.branchv   = br_cls;
            info.memv      = mem_cls;
            info.rs1       = use_rs1 ? inst[19:15] : 5'd0;
            info.rs2       = use_rs2 ? inst[24:20] : 5'd0;
            info.rd        = rd;
            info.we        = (rd != 5'd0);
            info.immv      = !is_opreg;
            info.sext      = sext;
            info.int_op    = int_op;
            info.branch_op = branch_op;
            info.mem_op    = mem_op;
            info.imm       = imm;
        end
    end

endmodule

// ==== decode_stage.sv ====
module decode_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  rv_decode_pkg::decode_info_t  dec_info,
    input  logic                         inst_valid,
    input  logic                         flush,
    output rv_decode_pkg::decode_info_t  info,
    output logic                         info_valid
);

    logic capture;

    // Flush wins over a strobe on the same edge.
    assign capture = inst_valid && !flush;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Valid flag
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            info_valid <= 1'b0;
        end else begin
            info_valid <= capture;  // High for exactly one cycle per strobe.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded record
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            info <= '0;
        end else if (capture) begin
            info <= dec_info;  // Otherwise the last record is held.
        end
    end

endmodule

// ==== decode_top.sv ====
module decode_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         inst_valid,
    input  logic [31:0]                  inst,
    input  logic                         flush,
    output rv_decode_pkg::decode_info_t  info,
    output logic                         info_valid
);

    rv_decode_pkg::decode_info_t dec_info;  // Combinational decode of the current word.

    inst_decoder i_inst_decoder (
        .inst (inst),
        .info (dec_info)
    );

    decode_stage i_decode_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_info   (dec_info),
        .inst_valid (inst_valid),
        .flush      (flush),
        .info       (info),
        .info_valid (info_valid)
    );

endmodule

// ==== decode_chk.sv ====
module decode_chk (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        flush,
    input logic                        info_valid,
    input rv_decode_pkg::decode_info_t info
);

    timeunit 1ns;
    timeprecision 100ps;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output record rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_one_class: assert property (@(posedge clk) disable iff (!rst_n)
        info_valid |-> $onehot({info.intv, info.branchv, info.memv, info.illegal}))
        else $error("decode_chk: class flags of a valid record are not one-hot");

    a_we_rd: assert property (@(posedge clk) disable iff (!rst_n)
        info.we |-> (info.rd != 5'd0))
        else $error("decode_chk: we is set with rd equal to x0");

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !info_valid)  // The record behind a flush is dropped.
        else $error("decode_chk: info_valid high in the cycle after flush");

endmodule

// ==== decode_tb.sv ====
module decode_tb;

    timeunit 1ns;
    timeprecision 100ps;

    parameter int SEED = 75045;

    localparam int W        = $bits(rv_decode_pkg::decode_info_t);
    localparam int N_DIR    = 9 * 16;
    localparam int N_ILL    = 128 + 24;
    localparam int N_STREAM = 400;
    localparam int N_GAP    = 200;
    localparam int LIMIT    = 12 + N_DIR + N_ILL + N_STREAM + N_GAP * 4 + 5 * 4 + 200;

    logic                        clk;
    logic                        rst_n;
    logic                        inst_valid;
    logic [31:0]                 inst;
    logic                        flush;
    rv_decode_pkg::decode_info_t info;
    logic                        info_valid;

    integer                      seed;
    int                          errors;
    int                          test_err0;
    int                          tests_passed;
    int                          tests_failed;
    int                          cycles;
    rv_decode_pkg::decode_info_t exp_q[$];    // Records still in flight, oldest first.
    rv_decode_pkg::opcode_e      op_list [9] = '{
        rv_decode_pkg::OP_LUI,  rv_decode_pkg::OP_AUIPC,  rv_decode_pkg::OP_JAL,
        rv_decode_pkg::OP_JALR, rv_decode_pkg::OP_BRANCH, rv_decode_pkg::OP_LOAD,
        rv_decode_pkg::OP_STORE, rv_decode_pkg::OP_OPIMM, rv_decode_pkg::OP_OPREG
    };

    decode_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .flush      (flush),
        .info       (info),
        .info_valid (info_valid)
    );

    bind decode_top decode_chk i_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .info_valid (info_valid),
        .info       (info)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [rv_decode_pkg::XLEN-1:0] ext(input logic [31:0] v,
                                                          input int msb, input logic zx);
        logic [rv_decode_pkg::XLEN-1:0] x;
        for (int i = 0; i < rv_decode_pkg::XLEN; i++) begin
            x[i] = (i <= msb) ? v[i] : (zx ? 1'b0 : v[msb]);
        end
        return x;
    endfunction

    function automatic rv_decode_pkg::int_op_e alu_ref(input logic [2:0] f3, input logic b30,
                                                       input logic is_reg);
        case (f3)
            3'd0:    return (is_reg && b30) ? rv_decode_pkg::INT_SUB : rv_decode_pkg::INT_ADD;
            3'd1:    return rv_decode_pkg::INT_SLL;
            3'd2:    return rv_decode_pkg::INT_SLT;
            3'd3:    return rv_decode_pkg::INT_SLTU;
            3'd4:    return rv_decode_pkg::INT_XOR;
            3'd5:    return b30 ? rv_decode_pkg::INT_SRA : rv_decode_pkg::INT_SRL;
            3'd6:    return rv_decode_pkg::INT_OR;
            default: return rv_decode_pkg::INT_AND;
        endcase
    endfunction

    function automatic rv_decode_pkg::decode_info_t ref_decode(input logic [31:0] w);
        rv_decode_pkg::decode_info_t r;
        logic [2:0]                  f3;
        logic                        bad;
        r   = '0;
        f3  = w[14:12];
        bad = (w[1:0] != 2'b11);
        case (w[6:2])
            rv_decode_pkg::OP_LUI, rv_decode_pkg::OP_AUIPC: begin
                r.intv   = 1'b1;
                r.rd     = w[11:7];
                r.int_op = (w[6:2] == rv_decode_pkg::OP_LUI) ? rv_decode_pkg::INT_LUI
                                                             : rv_decode_pkg::INT_AUIPC;
                r.imm    = ext({12'b0, w[31:12]}, 19, 1'b0);
            end
            rv_decode_pkg::OP_JAL: begin
                r.branchv   = 1'b1;
                r.rd        = w[11:7];
                r.branch_op = rv_decode_pkg::BR_JAL;
                r.imm = ext({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 20, 1'b0);
            end
            rv_decode_pkg::OP_JALR: begin
                r.branchv   = 1'b1;
                r.rs1       = w[19:15];
                r.rd        = w[11:7];
                r.branch_op = rv_decode_pkg::BR_JALR;
                r.imm       = ext({20'b0, w[31:20]}, 11, 1'b1);
            end
            rv_decode_pkg::OP_BRANCH: begin
                r.branchv = 1'b1;
                r.rs1     = w[19:15];
                r.rs2     = w[24:20];
                r.sext    = (f3 == 3'd4) || (f3 == 3'd5);  // BLT and BGE.
                r.imm = ext({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 12, 1'b0);
                case (f3)
                    3'd0:    r.branch_op = rv_decode_pkg::BR_EQ;
                    3'd1:    r.branch_op = rv_decode_pkg::BR_NE;
                    3'd4:    r.branch_op = rv_decode_pkg::BR_LT;
                    3'd5:    r.branch_op = rv_decode_pkg::BR_GE;
                    3'd6:    r.branch_op = rv_decode_pkg::BR_LTU;
                    3'd7:    r.branch_op = rv_decode_pkg::BR_GEU;
                    default: bad = 1'b1;
                endcase
            end
            rv_decode_pkg::OP_LOAD: begin
                r.memv = 1'b1;
                r.rs1  = w[19:15];
                r.rd   = w[11:7];
                r.sext = (f3 == 3'd0) || (f3 == 3'd1);
                r.imm  = ext({20'b0, w[31:20]}, 11, f3[2]);  // LBU and LHU zero-extend.
                case (f3)
                    3'd0:    r.mem_op = rv_decode_pkg::MEM_LB;
                    3'd1:    r.mem_op = rv_decode_pkg::MEM_LH;
                    3'd2:    r.mem_op = rv_decode_pkg::MEM_LW;
                    3'd4:    r.mem_op = rv_decode_pkg::MEM_LBU;
                    3'd5:    r.mem_op = rv_decode_pkg::MEM_LHU;
                    default: bad = 1'b1;
                endcase
            end
            rv_decode_pkg::OP_STORE: begin
                r.memv = 1'b1;
                r.rs1  = w[19:15];
                r.rs2  = w[24:20];
                r.imm  = ext({20'b0, w[31:25], w[11:7]}, 11, 1'b0);
                case (f3)
                    3'd0:    r.mem_op = rv_decode_pkg::MEM_SB;
                    3'd1:    r.mem_op = rv_decode_pkg::MEM_SH;
                    3'd2:    r.mem_op = rv_decode_pkg::MEM_SW;
                    default: bad = 1'b1;
                endcase
            end
            rv_decode_pkg::OP_OPIMM, rv_decode_pkg::OP_OPREG: begin
                r.intv   = 1'b1;
                r.rs1    = w[19:15];
                r.rd     = w[11:7];
                r.sext   = (f3 == 3'd2);
                r.int_op = alu_ref(f3, w[30], w[6:2] == rv_decode_pkg::OP_OPREG);
                if (w[6:2] == rv_decode_pkg::OP_OPREG) begin
                    r.rs2 = w[24:20];
                end else if (f3[1:0] == 2'b01) begin
                    r.imm = ext({27'b0, w[24:20]}, 4, 1'b1);  // Shift amount.
                end else begin
                    r.imm = ext({20'b0, w[31:20]}, 11, f3 == 3'd3);
                end
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            r         = '0;
            r.illegal = 1'b1;
        end else begin
            r.we   = (r.rd != 5'd0);
            r.immv = (w[6:2] != rv_decode_pkg::OP_OPREG);
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [W-1:0] exp,
                               input logic [W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_record(input rv_decode_pkg::decode_info_t e,
                                  input rv_decode_pkg::decode_info_t a);
        check_value("info", e, a);
        check_value("info.intv", W'(e.intv), W'(a.intv));
        check_value("info.branchv", W'(e.branchv), W'(a.branchv));
        check_value("info.memv", W'(e.memv), W'(a.memv));
        check_value("info.illegal", W'(e.illegal), W'(a.illegal));
        check_value("info.rs1", W'(e.rs1), W'(a.rs1));
        check_value("info.rs2", W'(e.rs2), W'(a.rs2));
        check_value("info.rd", W'(e.rd), W'(a.rd));
        check_value("info.we", W'(e.we), W'(a.we));
        check_value("info.immv", W'(e.immv), W'(a.immv));
        check_value("info.sext", W'(e.sext), W'(a.sext));
        check_value("info.int_op", W'(e.int_op), W'(a.int_op));
        check_value("info.branch_op", W'(e.branch_op), W'(a.branch_op));
        check_value("info.mem_op", W'(e.mem_op), W'(a.mem_op));
        check_value("info.imm", W'(e.imm), W'(a.imm));
    endtask

    always @(negedge clk) begin : compare_proc
        rv_decode_pkg::decode_info_t exp_rec;
        if (rst_n && info_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("%0t ns: info_valid was high with no instruction outstanding", $time);
                errors++;
            end else begin
                exp_rec = exp_q.pop_front();
                compare_record(exp_rec, info);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_word(input logic [31:0] w, input logic fl);
        @(posedge clk);
        inst       <= w;
        inst_valid <= 1'b1;
        flush      <= fl;
        if (!fl) exp_q.push_back(ref_decode(w));  // A flushed strobe never reaches the output.
    endtask

    task automatic idle_cycle(input logic fl);
        @(posedge clk);
        inst_valid <= 1'b0;
        flush      <= fl;
    endtask

    task automatic random_word(output logic [31:0] w);
        logic [31:0] r;
        int          sel;
        r   = $random(seed);
        sel = $unsigned($random(seed)) % 10;
        if (sel < 9) w = {r[31:7], op_list[sel], 2'b11};
        else w = {r[31:7], 5'b11100, r[1:0]};  // SYSTEM opcode or bad low bits.
    endtask

    task automatic finish_test(input string name);
        idle_cycle(1'b0);
        repeat (2) @(negedge clk);  // The last strobe shows up one cycle later.
        if (exp_q.size() != 0) begin
            $display("[%s] %0d expected records never left the stage", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        if (errors == test_err0) begin
            tests_passed++;
            $display("[%s] ok", name);
        end else begin
            tests_failed++;
            $display("[%s] %0d mismatches", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    initial begin : timeout_proc
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin : main_proc
        logic [31:0] r;
        logic [31:0] w;
        seed         = SEED;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        flush        = 1'b0;
        errors       = 0;
        test_err0    = 0;
        tests_passed = 0;
        tests_failed = 0;

        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            if (i == 9) rst_n <= 1'b1;  // Ten edges with reset low.
            @(negedge clk);
            check_value("info_valid", W'(1'b0), W'(info_valid));
            check_value("info", '0, info);
        end
        finish_test("reset");

        for (int oi = 0; oi < 9; oi++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    r = $random(seed);
                    w = {1'(alt), 1'(alt), r[29:15], 3'(f3),
                         (f3 == 2) ? 5'd0 : r[11:7], op_list[oi], 2'b11};
                    drive_word(w, 1'b0);
                end
            end
        end
        finish_test("directed");

        for (int opc = 0; opc < 32; opc++) begin
            for (int lo = 0; lo < 4; lo++) begin
                r = $random(seed);
                drive_word({r[31:7], 5'(opc), 2'(lo)}, 1'b0);
            end
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            r = $random(seed);
            drive_word({r[31:15], 3'(f3), r[11:7], rv_decode_pkg::OP_BRANCH, 2'b11}, 1'b0);
            drive_word({r[31:15], 3'(f3), r[11:7], rv_decode_pkg::OP_LOAD, 2'b11}, 1'b0);
            drive_word({r[31:15], 3'(f3), r[11:7], rv_decode_pkg::OP_STORE, 2'b11}, 1'b0);
        end
        finish_test("illegal");

        for (int k = 0; k < N_STREAM; k++) begin
            random_word(w);
            drive_word(w, 1'b0);
            @(negedge clk);
            if (k > 0) check_value("info_valid", W'(1'b1), W'(info_valid));
        end
        finish_test("stream");

        for (int k = 0; k < N_GAP; k++) begin
            random_word(w);
            r = $random(seed);
            drive_word(w, r[2:0] == 3'd0);
            repeat (r[5:4]) idle_cycle(r[7:6] == 2'd0);
        end
        finish_test("gaps_flush");

        $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
rv_decode_pkg.sv
imm_gen.sv
inst_decoder.sv
decode_stage.sv
decode_top.sv
decode_chk.sv
decode_tb.sv

// ==== Makefile ====
# Verilator build and run of the RV32I decode stage testbench.

TOP       ?= decode_tb
SEED      ?= 75045
VERILATOR ?= verilator
LOG       ?= sim.log
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: run build lint clean

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
